// File: include/cache_config.svh
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// processor and bus byte address
`define CACHE_ADDR_W 16

// line geometry
`define CACHE_LINE_BYTES 16
`define CACHE_LINES 32

// address split into tag, index and offset
`define CACHE_OFFSET_W 4
`define CACHE_INDEX_W 5
`define CACHE_TAG_W 7

// log2 of the access size, 0 to 4
`define CACHE_SIZE_W 3

`endif

// File: hw/cache_pkg.sv
`include "cache_config.svh"

package cache_pkg;

   typedef logic [`CACHE_ADDR_W-1:0] addr_t;
   typedef logic [`CACHE_LINE_BYTES*8-1:0] line_t;
   typedef logic [`CACHE_LINE_BYTES-1:0] byte_mask_t;
   typedef logic [`CACHE_TAG_W-1:0] tag_t;
   typedef logic [`CACHE_INDEX_W-1:0] index_t;
   typedef logic [`CACHE_OFFSET_W-1:0] offset_t;
   typedef logic [`CACHE_SIZE_W-1:0] size_code_t;

   typedef enum logic [3:0] {
      st_idle,
      st_rd,
      st_rd_hit,
      st_rd_miss,
      st_rd_evict,
      st_wr,
      st_wr_hit,
      st_wr_miss,
      st_wr_evict
   } cache_state_e;

   // data sits in the low bytes of wdata
   typedef struct packed {
      logic en;
      logic we;
      addr_t addr;
      size_code_t size;
      line_t wdata;
   } cpu_req_t;

   typedef struct packed {
      logic req;
      logic we;
      addr_t addr;
      line_t wdata;
   } bus_req_t;

   typedef struct packed {
      logic ack;
      line_t rdata;
   } bus_rsp_t;

endpackage

// File: hw/byte_align.sv
`timescale 1ns/1ps
`include "cache_config.svh"

module byte_align (
   input  cache_pkg::cpu_req_t   acc,
   input  cache_pkg::line_t      line_rd,
   output cache_pkg::line_t      store_data,
   output cache_pkg::byte_mask_t store_mask,
   output cache_pkg::line_t      rdata
);
   import cache_pkg::*;

   offset_t offset;
   byte_mask_t size_mask;
   line_t left [`CACHE_OFFSET_W+1];
   line_t right [`CACHE_OFFSET_W+1];
   byte_mask_t mask_sh [`CACHE_OFFSET_W+1];

   assign offset = acc.addr[`CACHE_OFFSET_W-1:0];

   // low 2**size bytes set
   always_comb
   begin
      case (acc.size)
         3'd0: size_mask = 16'h0001;
         3'd1: size_mask = 16'h0003;
         3'd2: size_mask = 16'h000f;
         3'd3: size_mask = 16'h00ff;
         default: size_mask = 16'hffff;
      endcase
   end

   assign left[0] = acc.wdata;
   assign right[0] = line_rd;
   assign mask_sh[0] = size_mask;

   // log shifter stage s moves by 2**s bytes
   for (genvar s = 0; s < `CACHE_OFFSET_W; s++)
   begin : g_shift
      assign left[s+1] = offset[s] ? (left[s] << (8 << s)) : left[s];
      assign right[s+1] = offset[s] ? (right[s] >> (8 << s)) : right[s];
      assign mask_sh[s+1] = offset[s] ? (mask_sh[s] << (1 << s)) : mask_sh[s];
   end

   assign store_data = left[`CACHE_OFFSET_W];
   assign store_mask = mask_sh[`CACHE_OFFSET_W];

   // zero filled from the top
   assign rdata = right[`CACHE_OFFSET_W];

endmodule

// File: hw/line_store.sv
`timescale 1ns/1ps
`include "cache_config.svh"

module line_store (
   input  logic                  clk,
   input  cache_pkg::cpu_req_t   acc,
   input  logic                  fill,
   input  logic                  store,
   input  cache_pkg::line_t      fill_data,
   input  cache_pkg::line_t      store_data,
   input  cache_pkg::byte_mask_t store_mask,
   output cache_pkg::line_t      line_rd
);
   import cache_pkg::*;

   line_t mem [`CACHE_LINES];
   index_t idx;
   line_t wr_data;
   byte_mask_t wr_en;

   assign idx = acc.addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W];

   // fill writes every byte of the line
   assign wr_data = fill ? fill_data : store_data;
   assign wr_en = fill ? '1 : (store ? store_mask : '0);

   // one enable per byte lane
   always_ff @(posedge clk)
   begin
      for (int b = 0; b < `CACHE_LINE_BYTES; b++)
      begin
         if (wr_en[b])
            mem[idx][b*8 +: 8] <= wr_data[b*8 +: 8];
      end
   end

   assign line_rd = mem[idx];

   a_fill_or_store: assert property (@(posedge clk)
      fill |-> !store);

endmodule

// File: hw/tag_store.sv
`timescale 1ns/1ps
`include "cache_config.svh"

module tag_store (
   input  logic                clk,
   input  logic                rst,
   input  cache_pkg::cpu_req_t acc,
   input  logic                fill,
   output logic                hit,
   output logic                victim,
   output cache_pkg::tag_t     victim_tag
);
   import cache_pkg::*;

   tag_t tags [`CACHE_LINES];
   logic [`CACHE_LINES-1:0] valid;
   tag_t acc_tag;
   index_t idx;
   logic match;

   assign acc_tag = acc.addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
   assign idx = acc.addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W];

   always_ff @(posedge clk)
   begin
      if (fill)
         tags[idx] <= acc_tag;
   end

   // a line becomes valid on its first fill and stays valid
   always_ff @(posedge clk)
   begin
      if (rst)
         valid <= '0;
      else if (fill)
         valid[idx] <= 1'b1;
   end

   assign victim_tag = tags[idx];
   assign match = (victim_tag == acc_tag);

   assign hit = valid[idx] && match;
   // resident line of another tag must be written back first
   assign victim = valid[idx] && !match;

   // the filled line hits on the next cycle
   a_fill_hits: assert property (@(posedge clk) disable iff (rst)
      fill |=> hit);

endmodule

// File: hw/cache_ctrl.sv
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_ctrl (
   input  logic                clk,
   input  logic                rst,
   input  cache_pkg::cpu_req_t cpu,
   input  logic                hit,
   input  logic                victim,
   input  cache_pkg::tag_t     victim_tag,
   input  cache_pkg::line_t    line_rd,
   input  cache_pkg::bus_rsp_t bus_rsp,
   output cache_pkg::cpu_req_t acc,
   output logic                fill,
   output logic                store,
   output logic                ready,
   output cache_pkg::bus_req_t bus
);
   import cache_pkg::*;

   cache_state_e state;
   cache_state_e state_next;
   logic ack_seen;
   logic evicting;
   logic missing;
   logic req_on;
   logic bus_done;
   index_t idx;
   tag_t acc_tag;

   assign idx = acc.addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
   assign acc_tag = acc.addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];

   assign evicting = (state == st_rd_evict) || (state == st_wr_evict);
   assign missing = (state == st_rd_miss) || (state == st_wr_miss);

   // req stays up until ack is seen and the state waits for ack to drop
   assign req_on = (evicting || missing) && !ack_seen;
   assign bus_done = ack_seen && !bus_rsp.ack;

   always_comb
   begin
      state_next = state;
      case (state)
         st_idle:
            if (cpu.en)
               state_next = cpu.we ? st_wr : st_rd;
         st_rd:
            if (hit)
               state_next = st_rd_hit;
            else if (victim)
               state_next = st_rd_evict;
            else
               state_next = st_rd_miss;
         st_wr:
            if (hit)
               state_next = st_wr_hit;
            else if (victim)
               state_next = st_wr_evict;
            else
               state_next = st_wr_miss;
         st_rd_hit, st_wr_hit:
            state_next = st_idle;
         // fetch the new line once the write-back is done
         st_rd_evict:
            if (bus_done)
               state_next = st_rd_miss;
         st_wr_evict:
            if (bus_done)
               state_next = st_wr_miss;
         // retry the filled access which now hits
         st_rd_miss:
            if (bus_done)
               state_next = st_rd;
         st_wr_miss:
            if (bus_done)
               state_next = st_wr;
         default:
            state_next = st_idle;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state <= st_idle;
         ack_seen <= 1'b0;
         acc <= '0;
      end
      else
      begin
         state <= state_next;
         if (state == st_idle && cpu.en)
            acc <= cpu;
         if (bus_done)
            ack_seen <= 1'b0;
         else if (req_on && bus_rsp.ack)
            ack_seen <= 1'b1;
      end
   end

   assign fill = missing && req_on && bus_rsp.ack;
   assign store = (state == st_wr_hit);
   assign ready = (state == st_rd_hit) || (state == st_wr_hit);

   always_comb
   begin
      bus.req = req_on;
      bus.we = evicting;
      // victim line address while writing back
      if (evicting)
         bus.addr = {victim_tag, idx, {`CACHE_OFFSET_W{1'b0}}};
      else
         bus.addr = {acc_tag, idx, {`CACHE_OFFSET_W{1'b0}}};
      bus.wdata = line_rd;
   end

   a_ready_pulse: assert property (@(posedge clk) disable iff (rst)
      ready |=> !ready);

   // four-phase rule on the cache side
   a_req_until_ack: assert property (@(posedge clk) disable iff (rst)
      $fell(bus.req) |-> $past(bus_rsp.ack));

   a_addr_stable: assert property (@(posedge clk) disable iff (rst)
      bus.req && $past(bus.req) |-> $stable(bus.addr));

endmodule

// File: hw/cache_top.sv
`timescale 1ns/1ps

module cache_top (
   input  logic                clk,
   input  logic                rst,
   input  cache_pkg::cpu_req_t cpu,
   output cache_pkg::line_t    rdata,
   output logic                ready,
   input  cache_pkg::bus_rsp_t bus_rsp,
   output cache_pkg::bus_req_t bus
);
   import cache_pkg::*;

   cpu_req_t acc;
   logic fill;
   logic store;
   logic hit;
   logic victim;
   tag_t victim_tag;
   line_t line_rd;
   line_t store_data;
   byte_mask_t store_mask;

   cache_ctrl u_ctrl (
      .clk        (clk),
      .rst        (rst),
      .cpu        (cpu),
      .hit        (hit),
      .victim     (victim),
      .victim_tag (victim_tag),
      .line_rd    (line_rd),
      .bus_rsp    (bus_rsp),
      .acc        (acc),
      .fill       (fill),
      .store      (store),
      .ready      (ready),
      .bus        (bus)
   );

   tag_store u_tags (
      .clk        (clk),
      .rst        (rst),
      .acc        (acc),
      .fill       (fill),
      .hit        (hit),
      .victim     (victim),
      .victim_tag (victim_tag)
   );

   // fills come straight from the bus
   line_store u_lines (
      .clk        (clk),
      .acc        (acc),
      .fill       (fill),
      .store      (store),
      .fill_data  (bus_rsp.rdata),
      .store_data (store_data),
      .store_mask (store_mask),
      .line_rd    (line_rd)
   );

   byte_align u_align (
      .acc        (acc),
      .line_rd    (line_rd),
      .store_data (store_data),
      .store_mask (store_mask),
      .rdata      (rdata)
   );

endmodule

// File: sim/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
   output logic clk,
   output logic rst
);

   // 4 ns period
   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // held over the first four rising edges
   initial
   begin
      rst = 1'b1;
      repeat (4) @(posedge clk);
      rst <= 1'b0;
   end

endmodule

// File: sim/cache_tb.sv
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_tb;
   import cache_pkg::*;

   localparam int NUM_STEPS = 300;
   localparam int MAX_WAIT = 200;

   logic clk;
   logic rst;
   cpu_req_t cpu;
   line_t rdata;
   logic ready;
   bus_rsp_t bus_rsp;
   bus_req_t bus;

   // expected behavior of the access in flight
   logic exp_we;
   logic exp_hit;
   logic exp_evict;
   addr_t exp_line;
   addr_t exp_victim;
   line_t exp_victim_data;
   line_t exp_rdata;
   line_t exp_rmask;

   logic wb_seen;
   logic fetch_seen;
   logic en_q;
   logic [7:0] lat;

   logic [7:0] mem [65536];
   logic [7:0] shadow [65536];
   logic [1:0] delay_cnt;
   logic [31:0] mem_rng;
   logic [31:0] stim_rng;
   logic [`CACHE_LINES-1:0] model_valid;
   tag_t model_tag [`CACHE_LINES];

   tb_clock u_clock (
      .clk (clk),
      .rst (rst)
   );

   cache_top dut (
      .clk     (clk),
      .rst     (rst),
      .cpu     (cpu),
      .rdata   (rdata),
      .ready   (ready),
      .bus_rsp (bus_rsp),
      .bus     (bus)
   );

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // power-up memory contents from every address bit
   function automatic logic [7:0] init_byte(input addr_t a);
      return a[7:0] ^ {a[12:8], a[15:13]} ^ 8'h5a;
   endfunction

   // few tags over few lines so evictions are frequent
   function automatic tag_t pick_tag(input logic [1:0] k);
      case (k)
         2'd0: return 7'h00;
         2'd1: return 7'h01;
         2'd2: return 7'h2a;
         default: return 7'h7f;
      endcase
   endfunction

   task automatic fail_with(input string line);
      $display("%s", line);
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic run_access(input logic we, input addr_t addr, input size_code_t size,
                             input line_t wdata);
      index_t idx;
      tag_t tag;
      addr_t vbase;
      line_t rd_exp;
      line_t rd_mask;
      line_t vdata;
      int waited;
      idx = addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
      tag = addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
      vbase = {model_tag[idx], idx, 4'h0};
      rd_exp = '0;
      rd_mask = '0;
      for (int b = 0; b < `CACHE_LINE_BYTES; b++)
      begin
         vdata[b*8 +: 8] = shadow[vbase + addr_t'(b)];
         if (b < (1 << size))
         begin
            rd_exp[b*8 +: 8] = shadow[addr + addr_t'(b)];
            rd_mask[b*8 +: 8] = 8'hff;
            if (we)
               shadow[addr + addr_t'(b)] = wdata[b*8 +: 8];
         end
      end
      @(posedge clk);
      exp_we <= we;
      exp_hit <= model_valid[idx] && (model_tag[idx] == tag);
      exp_evict <= model_valid[idx] && (model_tag[idx] != tag);
      exp_line <= {addr[15:4], 4'h0};
      exp_victim <= vbase;
      exp_victim_data <= vdata;
      exp_rdata <= rd_exp;
      exp_rmask <= rd_mask;
      model_valid[idx] = 1'b1;
      model_tag[idx] = tag;
      cpu.en <= 1'b1;
      cpu.we <= we;
      cpu.addr <= addr;
      cpu.size <= size;
      cpu.wdata <= wdata;
      waited = 0;
      @(negedge clk);
      while (!ready && waited < MAX_WAIT)
      begin
         @(negedge clk);
         waited++;
      end
      if (!ready)
         fail_with("no ready from the cache within the timeout");
      // en drops on the edge that samples ready
      @(posedge clk);
      cpu.en <= 1'b0;
   endtask

   task automatic random_step();
      logic [31:0] r;
      size_code_t size;
      addr_t addr;
      line_t wdata;
      stim_rng = xorshift(stim_rng);
      r = stim_rng;
      size = size_code_t'(r[7:0] % 8'd5);
      addr = {pick_tag(r[9:8]), 2'b00, r[12:10], r[16:13] & ~((4'd1 << size) - 4'd1)};
      for (int w = 0; w < 4; w++)
      begin
         stim_rng = xorshift(stim_rng);
         wdata[w*32 +: 32] = stim_rng;
      end
      if (r[17])
         @(posedge clk);
      run_access(r[18], addr, size, wdata);
      // whole line read back after a write
      if (r[18] && r[19])
         run_access(1'b0, {addr[15:4], 4'h0}, 3'd4, '0);
   endtask

   // bus memory with a random delay before each ack edge
   initial
   begin
      bus_rsp = '0;
      delay_cnt = 2'd0;
      mem_rng = 32'd69;
      for (int i = 0; i < 65536; i++)
         mem[i[15:0]] = init_byte(i[15:0]);
      forever
      begin
         @(posedge clk);
         if (rst)
         begin
            bus_rsp.ack <= 1'b0;
            delay_cnt <= 2'd0;
         end
         else if (bus_rsp.ack && !bus.req)
         begin
            if (delay_cnt == 2'd0)
            begin
               bus_rsp.ack <= 1'b0;
               delay_cnt <= mem_rng[1:0];
               mem_rng <= xorshift(mem_rng);
            end
            else
               delay_cnt <= delay_cnt - 2'd1;
         end
         else if (!bus_rsp.ack && bus.req)
         begin
            if (delay_cnt == 2'd0)
            begin
               bus_rsp.ack <= 1'b1;
               for (int b = 0; b < `CACHE_LINE_BYTES; b++)
               begin
                  if (bus.we)
                     mem[bus.addr + addr_t'(b)] = bus.wdata[b*8 +: 8];
                  else
                     bus_rsp.rdata[b*8 +: 8] <= mem[bus.addr + addr_t'(b)];
               end
               delay_cnt <= mem_rng[3:2];
               mem_rng <= xorshift(mem_rng);
            end
            else
               delay_cnt <= delay_cnt - 2'd1;
         end
      end
   end

   // bus traffic and hit latency of the access in flight
   always @(posedge clk)
   begin
      if (rst)
      begin
         en_q <= 1'b0;
         lat <= 8'd0;
         wb_seen <= 1'b0;
         fetch_seen <= 1'b0;
      end
      else
      begin
         en_q <= cpu.en;
         if (cpu.en && !en_q)
            lat <= 8'd1;
         else if (cpu.en)
            lat <= lat + 8'd1;
         if (ready)
         begin
            wb_seen <= 1'b0;
            fetch_seen <= 1'b0;
         end
         else if (bus.req && bus.we)
            wb_seen <= 1'b1;
         else if (bus.req)
            fetch_seen <= 1'b1;
      end
   end

   a_reset_idle: assert property (@(posedge clk) rst |=> !ready && !bus.req)
      else fail_with("ready or bus request high right after reset");

   a_read_data: assert property (@(posedge clk) disable iff (rst)
      ready && !exp_we |-> ((rdata ^ exp_rdata) & exp_rmask) == '0)
      else fail_with($sformatf("Fail rdata got %h expected %h mask %h",
         $sampled(rdata), $sampled(exp_rdata), $sampled(exp_rmask)));

   a_miss_fetch: assert property (@(posedge clk) disable iff (rst)
      ready && !exp_hit |-> fetch_seen)
      else fail_with("a miss completed without a bus read of its line");

   a_evict_write: assert property (@(posedge clk) disable iff (rst)
      ready && exp_evict |-> wb_seen)
      else fail_with("an eviction completed without a bus write-back");

   a_writeback: assert property (@(posedge clk) disable iff (rst)
      $rose(bus.req) && exp_evict && !wb_seen |->
         bus.we && bus.addr == exp_victim && bus.wdata == exp_victim_data)
      else fail_with($sformatf("Fail bus we %h addr %h wdata %h expected addr %h wdata %h",
         $sampled(bus.we), $sampled(bus.addr), $sampled(bus.wdata),
         $sampled(exp_victim), $sampled(exp_victim_data)));

   a_fetch: assert property (@(posedge clk) disable iff (rst)
      $rose(bus.req) && !(exp_evict && !wb_seen) |-> !bus.we && bus.addr == exp_line)
      else fail_with($sformatf("Fail bus we %h addr %h expected we 0 addr %h",
         $sampled(bus.we), $sampled(bus.addr), $sampled(exp_line)));

   a_hit_latency: assert property (@(posedge clk) disable iff (rst)
      ready && exp_hit |-> lat == 8'd2)
      else fail_with($sformatf("Fail ready latency %h expected 02", $sampled(lat)));

   a_hit_no_bus: assert property (@(posedge clk) disable iff (rst)
      $rose(bus.req) |-> !exp_hit)
      else fail_with("bus request issued for an access that should hit");

   a_req_holds: assert property (@(posedge clk) disable iff (rst)
      bus.req && !bus_rsp.ack |=> bus.req)
      else fail_with("bus request dropped before ack rose");

   a_req_after_ack: assert property (@(posedge clk) disable iff (rst)
      $rose(bus.req) |-> !bus_rsp.ack)
      else fail_with("bus request raised while ack was still high");

   initial
   begin
      int waited;
      cpu = '0;
      stim_rng = 32'd69;
      model_valid = '0;
      model_tag = '{default: '0};
      exp_we = 1'b0;
      exp_hit = 1'b0;
      exp_evict = 1'b0;
      for (int i = 0; i < 65536; i++)
         shadow[i[15:0]] = init_byte(i[15:0]);
      waited = 0;
      @(posedge clk);
      while (rst && waited < MAX_WAIT)
      begin
         @(posedge clk);
         waited++;
      end
      if (rst)
         fail_with("reset was never released");
      for (int n = 0; n < NUM_STEPS; n++)
         random_step();
      $display("Simulation completed successfully");
      $finish;
   end

endmodule

// File: sim.f
+incdir+include
hw/cache_pkg.sv
hw/byte_align.sv
hw/line_store.sv
hw/tag_store.sv
hw/cache_ctrl.sv
hw/cache_top.sv
sim/tb_clock.sv
sim/cache_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
   -f sim.f --top-module cache_tb -o cache_sim
./obj_dir/cache_sim
